// ==== src/cpu_cfg_pkg.sv ====
package cpu_cfg_pkg;

    // Datapath and memory widths
    localparam int DATA_BITS     = 8;
    localparam int MEM_ADDR_BITS = 8;
    localparam int REG_ADDR_BITS = 3;

    // Storage sizes
    localparam int REG_COUNT = 8;
    localparam int MEM_BYTES = 256;

    // Register and memory data word
    typedef logic [DATA_BITS-1:0] data_t;

    // Byte address into the unified memory
    typedef logic [MEM_ADDR_BITS-1:0] mem_addr_t;

    // Register file index
    typedef logic [REG_ADDR_BITS-1:0] reg_addr_t;

endpackage

// ==== src/isa_pkg.sv ====
package isa_pkg;

    typedef enum logic [3:0] {
        MOVIR = 4'b0000,
        LOAD  = 4'b0010,
        STORE = 4'b0011,
        ADDRR = 4'b0100,
        ADDI  = 4'b0101,
        SUBRR = 4'b0110,
        SUBI  = 4'b0111,
        JNZI  = 4'b1000,
        JZR   = 4'b1001,
        NOP   = 4'b1111
    } opcode_t;

    typedef logic [15:0] instr_t;

    // Bytes per instruction, stored big-endian
    localparam int INSTR_BYTES = 2;

    // Field positions inside instr_t
    localparam int OPCODE_MSB = 15;
    localparam int OPCODE_LSB = 12;
    localparam int DST_MSB    = 10;
    localparam int DST_LSB    = 8;
    localparam int IMM_MSB    = 7;
    localparam int IMM_LSB    = 0;
    localparam int SRC0_MSB   = 6;
    localparam int SRC0_LSB   = 4;
    localparam int SRC1_MSB   = 2;
    localparam int SRC1_LSB   = 0;

    typedef enum logic [2:0] {
        IDLE,
        INSTR_FETCH_START,
        INSTR_FETCH_END,
        REGISTER_FETCH,
        EXECUTE,
        REGISTER_WB,
        LOAD_STAGE,
        STORE_STAGE
    } exec_stage_t;

endpackage

// ==== src/alu.sv ====
`timescale 1ns/1ns

module alu
    import cpu_cfg_pkg::*;
(
    input  data_t a,
    input  data_t b,
    input  logic  subtract,
    output data_t result,
    output logic  zero
);

    data_t sum;
    data_t diff;

    // Both results wrap modulo 256
    assign sum  = a + b;
    assign diff = a - b;

    assign result = subtract ? diff : sum;
    assign zero   = (result == '0);

endmodule

// ==== src/register_file.sv ====
`timescale 1ns/1ns

module register_file
    import cpu_cfg_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    input  reg_addr_t rd0_addr,
    output data_t     rd0_data,

    input  reg_addr_t rd1_addr,
    output data_t     rd1_data,

    input  logic      wr_en,
    input  reg_addr_t wr_addr,
    input  data_t     wr_data
);

    data_t regs [REG_COUNT];

    // Combinational reads see the value before a same-cycle write
    assign rd0_data = regs[rd0_addr];
    assign rd1_data = regs[rd1_addr];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

// ==== src/unified_ram.sv ====
`timescale 1ns/1ns

module unified_ram
    import cpu_cfg_pkg::*;
(
    input  logic      clk,

    input  logic      rd_en,
    input  mem_addr_t rd_addr,
    output data_t     rd_data,

    input  logic      wr_en,
    input  mem_addr_t wr_addr,
    input  data_t     wr_data,

    input  logic      load_en,
    input  mem_addr_t load_addr,
    input  data_t     load_data
);

    data_t mem [MEM_BYTES];

    // Loader wins over the CPU port
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end else if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // One cycle read latency, output holds while idle
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// ==== src/exec_unit.sv ====
`timescale 1ns/1ns

module exec_unit
    import cpu_cfg_pkg::*;
    import isa_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    output logic      mem_rd_en,
    output mem_addr_t mem_rd_addr,
    input  data_t     mem_rd_data,

    output logic      mem_wr_en,
    output mem_addr_t mem_wr_addr,
    output data_t     mem_wr_data,

    output reg_addr_t reg_rd0_addr,
    output reg_addr_t reg_rd1_addr,
    input  data_t     reg_rd0_data,
    input  data_t     reg_rd1_data,

    output logic      reg_wr_en,
    output reg_addr_t reg_wr_addr,
    output data_t     reg_wr_data,

    output data_t     alu_b,
    output logic      alu_subtract,
    input  data_t     alu_result,
    input  logic      alu_zero
);

    exec_stage_t state;
    mem_addr_t   pc;
    instr_t      ir;
    logic        zero_flag;
    logic        zero_pending;
    logic        save_zero;

    opcode_t     op;
    data_t       imm;
    reg_addr_t   dst;
    reg_addr_t   src0;
    reg_addr_t   src1;
    logic        is_reg_arith;
    logic        is_imm_arith;
    logic        is_arith;

    // Instruction fields
    assign op   = opcode_t'(ir[OPCODE_MSB:OPCODE_LSB]);
    assign imm  = ir[IMM_MSB:IMM_LSB];
    assign dst  = ir[DST_MSB:DST_LSB];
    assign src0 = ir[SRC0_MSB:SRC0_LSB];
    assign src1 = ir[SRC1_MSB:SRC1_LSB];

    assign is_reg_arith = (op == ADDRR) || (op == SUBRR);
    assign is_imm_arith = (op == ADDI) || (op == SUBI);
    assign is_arith     = is_reg_arith || is_imm_arith;

    // Immediate forms use the destination as first operand
    assign reg_rd0_addr = is_reg_arith ? src0 : dst;
    assign reg_rd1_addr = src1;
    assign reg_wr_addr  = dst;
    assign alu_b        = is_imm_arith ? imm : reg_rd1_data;
    assign alu_subtract = (op == SUBRR) || (op == SUBI);

    // Store data comes straight off read port 0
    assign mem_wr_en   = (state == STORE_STAGE);
    assign mem_wr_addr = imm;
    assign mem_wr_data = reg_rd0_data;

    always_comb begin
        mem_rd_en   = 1'b0;
        mem_rd_addr = pc;
        case (state)
            INSTR_FETCH_START: begin
                mem_rd_en = 1'b1;
            end
            INSTR_FETCH_END: begin
                mem_rd_en   = 1'b1;
                mem_rd_addr = pc + mem_addr_t'(1);
            end
            EXECUTE: begin
                if (op == LOAD) begin
                    mem_rd_en   = 1'b1;
                    mem_rd_addr = imm;
                end
            end
            default: begin
                mem_rd_en = 1'b0;
            end
        endcase
    end

    // Register write source by stage
    always_comb begin
        reg_wr_en   = 1'b0;
        reg_wr_data = alu_result;
        case (state)
            EXECUTE: begin
                if (op == MOVIR) begin
                    reg_wr_en   = 1'b1;
                    reg_wr_data = imm;
                end
            end
            LOAD_STAGE: begin
                reg_wr_en   = 1'b1;
                reg_wr_data = mem_rd_data;
            end
            REGISTER_WB: begin
                reg_wr_en = 1'b1;
            end
            default: begin
                reg_wr_en = 1'b0;
            end
        endcase
    end

    // Instruction bytes and the ALU zero before writeback changes a source
    always_ff @(posedge clk) begin
        if (state == INSTR_FETCH_END) begin
            ir[15:8] <= mem_rd_data;
        end
        if (state == REGISTER_FETCH) begin
            ir[7:0] <= mem_rd_data;
        end
        if (state == REGISTER_WB) begin
            zero_pending <= alu_zero;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= IDLE;
            pc        <= '0;
            zero_flag <= 1'b0;
            save_zero <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    state <= INSTR_FETCH_START;
                end
                INSTR_FETCH_START: begin
                    if (save_zero) begin
                        zero_flag <= zero_pending;
                    end
                    save_zero <= 1'b0;
                    state     <= INSTR_FETCH_END;
                end
                INSTR_FETCH_END: begin
                    state <= REGISTER_FETCH;
                end
                REGISTER_FETCH: begin
                    // Low byte on the read port is the jump target
                    if ((op == JNZI) && !zero_flag) begin
                        pc <= mem_rd_data;
                    end else begin
                        pc <= pc + mem_addr_t'(INSTR_BYTES);
                    end
                    state <= EXECUTE;
                end
                EXECUTE: begin
                    if (op == LOAD) begin
                        state <= LOAD_STAGE;
                    end else if (op == STORE) begin
                        state <= STORE_STAGE;
                    end else if (is_arith) begin
                        state <= REGISTER_WB;
                    end else begin
                        // mov, jnz, nop and jzr finish here
                        state <= INSTR_FETCH_START;
                    end
                end
                REGISTER_WB: begin
                    save_zero <= 1'b1;
                    state     <= INSTR_FETCH_START;
                end
                LOAD_STAGE, STORE_STAGE: begin
                    state <= INSTR_FETCH_START;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

// ==== src/tiny_cpu.sv ====
`timescale 1ns/1ns

module tiny_cpu
    import cpu_cfg_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    input  logic      load_en,
    input  mem_addr_t load_addr,
    input  data_t     load_data,

    output logic      store_en,
    output mem_addr_t store_addr,
    output data_t     store_data
);

    logic      mem_rd_en;
    mem_addr_t mem_rd_addr;
    data_t     mem_rd_data;

    reg_addr_t reg_rd0_addr;
    reg_addr_t reg_rd1_addr;
    data_t     reg_rd0_data;
    data_t     reg_rd1_data;
    logic      reg_wr_en;
    reg_addr_t reg_wr_addr;
    data_t     reg_wr_data;

    data_t     alu_b;
    logic      alu_subtract;
    data_t     alu_result;
    logic      alu_zero;

    exec_unit exec_unit_i (
        .clk          (clk),
        .reset        (reset),
        .mem_rd_en    (mem_rd_en),
        .mem_rd_addr  (mem_rd_addr),
        .mem_rd_data  (mem_rd_data),
        .mem_wr_en    (store_en),
        .mem_wr_addr  (store_addr),
        .mem_wr_data  (store_data),
        .reg_rd0_addr (reg_rd0_addr),
        .reg_rd1_addr (reg_rd1_addr),
        .reg_rd0_data (reg_rd0_data),
        .reg_rd1_data (reg_rd1_data),
        .reg_wr_en    (reg_wr_en),
        .reg_wr_addr  (reg_wr_addr),
        .reg_wr_data  (reg_wr_data),
        .alu_b        (alu_b),
        .alu_subtract (alu_subtract),
        .alu_result   (alu_result),
        .alu_zero     (alu_zero)
    );

    register_file register_file_i (
        .clk      (clk),
        .reset    (reset),
        .rd0_addr (reg_rd0_addr),
        .rd0_data (reg_rd0_data),
        .rd1_addr (reg_rd1_addr),
        .rd1_data (reg_rd1_data),
        .wr_en    (reg_wr_en),
        .wr_addr  (reg_wr_addr),
        .wr_data  (reg_wr_data)
    );

    // Operand a is always read port 0
    alu alu_i (
        .a        (reg_rd0_data),
        .b        (alu_b),
        .subtract (alu_subtract),
        .result   (alu_result),
        .zero     (alu_zero)
    );

    unified_ram unified_ram_i (
        .clk       (clk),
        .rd_en     (mem_rd_en),
        .rd_addr   (mem_rd_addr),
        .rd_data   (mem_rd_data),
        .wr_en     (store_en),
        .wr_addr   (store_addr),
        .wr_data   (store_data),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data)
    );

endmodule

// ==== sim/tiny_cpu_tb.sv ====
`timescale 1ns/1ns

module tiny_cpu_tb
    import cpu_cfg_pkg::*;
    import isa_pkg::*;
();

    logic      clk;
    logic      reset;
    logic      load_en;
    mem_addr_t load_addr;
    data_t     load_data;
    logic      store_en;
    mem_addr_t store_addr;
    data_t     store_data;

    // Program image, preloaded data and expected stores of the current run
    data_t     prog [$];
    mem_addr_t pre_addr [$];
    data_t     pre_data [$];
    mem_addr_t want_addr [$];
    data_t     want_data [$];

    // Every store seen on the top-level port, with its cycle number
    mem_addr_t seen_addr [$];
    data_t     seen_data [$];
    int        seen_cycle [$];

    logic [7:0] lfsr_state  = 8'd92;
    int         cycle_count = 0;
    int         run_cycles  = 0;
    int         cycle_limit = 200;
    int         test_errors = 0;
    int         pass_count  = 0;
    int         fail_count  = 0;

    tiny_cpu tiny_cpu_i (
        .clk        (clk),
        .reset      (reset),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .store_en   (store_en),
        .store_addr (store_addr),
        .store_data (store_data)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // Budget grows by 5 cycles per executed instruction as each program starts
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (!reset) begin
            run_cycles <= run_cycles + 1;
        end
        if (run_cycles > cycle_limit) begin
            $display("Timeout after %0d CPU cycles, a program did not produce all its stores",
                     run_cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    // Store monitor samples away from the rising edge
    always @(negedge clk) begin
        if (store_en) begin
            seen_addr.push_back(store_addr);
            seen_data.push_back(store_data);
            seen_cycle.push_back(cycle_count);
        end
    end

    // Galois form of x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 8'hB8;
        end
        return s >> 1;
    endfunction

    function automatic logic [7:0] random_bits(input int n);
        logic [7:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value      = {value[6:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return value;
    endfunction

    task automatic push_instr(input opcode_t op, input reg_addr_t dst, input data_t low);
        instr_t word;
        word = '0;
        word[OPCODE_MSB:OPCODE_LSB] = op;
        word[DST_MSB:DST_LSB]       = dst;
        word[IMM_MSB:IMM_LSB]       = low;
        // Big-endian, high byte at the even address
        prog.push_back(word[15:8]);
        prog.push_back(word[7:0]);
    endtask

    // mov and addi leave the zero flag clear, then jnz to itself
    task automatic park_cpu();
        push_instr(MOVIR, 3'd7, 8'd1);
        push_instr(ADDI, 3'd7, 8'd1);
        push_instr(JNZI, 3'd0, data_t'(prog.size()));
    endtask

    task automatic expect_store(input mem_addr_t addr, input data_t data);
        want_addr.push_back(addr);
        want_data.push_back(data);
    endtask

    task automatic clear_program();
        prog.delete();
        pre_addr.delete();
        pre_data.delete();
        want_addr.delete();
        want_data.delete();
    endtask

    task automatic run_program(input int n_exec, output int base);
        @(posedge clk);
        #1;
        reset = 1'b1;
        repeat (2) @(posedge clk);
        // Program bytes first, then the data bytes, one write per cycle
        for (int i = 0; i < prog.size() + pre_addr.size(); i++) begin
            #1;
            load_en = 1'b1;
            if (i < prog.size()) begin
                load_addr = mem_addr_t'(i);
                load_data = prog[i];
            end else begin
                load_addr = pre_addr[i - prog.size()];
                load_data = pre_data[i - prog.size()];
            end
            @(posedge clk);
        end
        #1;
        load_en     = 1'b0;
        cycle_limit = cycle_limit + 5 * n_exec;
        base        = seen_addr.size();
        reset       = 1'b0;
        while (seen_addr.size() < base + want_addr.size()) begin
            @(posedge clk);
        end
    endtask

    task automatic report_mismatch(input string name, input string what,
                                   input int expected, input int actual);
        test_errors++;
        $display("CHECK FAILED %s %s: expected %0d, actual %0d", name, what, expected, actual);
    endtask

    task automatic check_stores(input string name, input int base);
        for (int i = 0; i < want_addr.size(); i++) begin
            if (seen_addr[base + i] !== want_addr[i]) begin
                report_mismatch(name, $sformatf("store %0d address", i),
                                int'(want_addr[i]), int'(seen_addr[base + i]));
            end
            if (seen_data[base + i] !== want_data[i]) begin
                report_mismatch(name, $sformatf("store %0d data", i),
                                int'(want_data[i]), int'(seen_data[base + i]));
            end
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            pass_count++;
            $display("PASS %s", name);
        end else begin
            fail_count++;
            $display("FAIL %s with %0d mismatches", name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic mov_store();
        data_t value [8];
        int    base;
        clear_program();
        for (int r = 0; r < 8; r++) begin
            value[r] = random_bits(8);
            push_instr(MOVIR, reg_addr_t'(r), value[r]);
        end
        for (int r = 0; r < 8; r++) begin
            push_instr(STORE, reg_addr_t'(r), data_t'(8'h80 + r));
            expect_store(mem_addr_t'(8'h80 + r), value[r]);
        end
        park_cpu();
        run_program(19, base);
        check_stores("mov_store", base);
        finish_test("mov_store");
    endtask

    task automatic reg_arith();
        data_t     model [8];
        reg_addr_t ra;
        reg_addr_t rb;
        reg_addr_t rd;
        int        base;
        clear_program();
        for (int r = 0; r < 8; r++) begin
            model[r] = random_bits(8);
            push_instr(MOVIR, reg_addr_t'(r), model[r]);
        end
        for (int j = 0; j < 4; j++) begin
            ra = reg_addr_t'(random_bits(3));
            rb = reg_addr_t'(random_bits(3));
            rd = reg_addr_t'(random_bits(3));
            if (j % 2 == 0) begin
                push_instr(ADDRR, rd, {1'b0, ra, 1'b0, rb});
                model[rd] = model[ra] + model[rb];
            end else begin
                push_instr(SUBRR, rd, {1'b0, ra, 1'b0, rb});
                model[rd] = model[ra] - model[rb];
            end
            push_instr(STORE, rd, data_t'(8'h90 + j));
            expect_store(mem_addr_t'(8'h90 + j), model[rd]);
        end
        park_cpu();
        run_program(19, base);
        check_stores("reg_arith", base);
        finish_test("reg_arith");
    endtask

    task automatic imm_arith();
        data_t   start [4];
        data_t   k [4];
        opcode_t op [4];
        data_t   result;
        int      base;
        clear_program();
        // Case 0 wraps past 255, case 1 goes below 0
        start[0] = 8'hF0 | random_bits(4);
        k[0]     = 8'h20 | random_bits(4);
        start[1] = random_bits(4);
        k[1]     = 8'h10 | random_bits(4);
        start[2] = random_bits(8);
        k[2]     = random_bits(8);
        start[3] = random_bits(8);
        k[3]     = random_bits(8);
        op[0]    = ADDI;
        op[1]    = SUBI;
        op[2]    = ADDI;
        op[3]    = SUBI;
        for (int i = 0; i < 4; i++) begin
            push_instr(MOVIR, reg_addr_t'(i), start[i]);
            push_instr(op[i], reg_addr_t'(i), k[i]);
            push_instr(STORE, reg_addr_t'(i), data_t'(8'h98 + i));
            if (op[i] == ADDI) begin
                result = start[i] + k[i];
            end else begin
                result = start[i] - k[i];
            end
            expect_store(mem_addr_t'(8'h98 + i), result);
        end
        park_cpu();
        run_program(15, base);
        check_stores("imm_arith", base);
        finish_test("imm_arith");
    endtask

    task automatic load_path();
        data_t stored;
        data_t k;
        int    base;
        clear_program();
        for (int i = 0; i < 3; i++) begin
            stored = random_bits(8);
            k      = random_bits(8);
            pre_addr.push_back(mem_addr_t'(8'hF0 + i));
            pre_data.push_back(stored);
            push_instr(LOAD, reg_addr_t'(i + 1), data_t'(8'hF0 + i));
            push_instr(ADDI, reg_addr_t'(i + 1), k);
            push_instr(STORE, reg_addr_t'(i + 1), data_t'(8'hA0 + i));
            expect_store(mem_addr_t'(8'hA0 + i), stored + k);
        end
        park_cpu();
        run_program(12, base);
        check_stores("load_path", base);
        finish_test("load_path");
    endtask

    task automatic jnz_loop();
        data_t loop_top;
        data_t marker;
        int    n;
        int    base;
        clear_program();
        n      = int'(random_bits(3)) % 6 + 1;
        marker = random_bits(8);
        push_instr(MOVIR, 3'd1, data_t'(n));
        loop_top = data_t'(prog.size());
        push_instr(STORE, 3'd1, 8'hB0);
        push_instr(SUBI, 3'd1, 8'd1);
        push_instr(JNZI, 3'd0, loop_top);
        // Reached only once the counter hits zero
        push_instr(MOVIR, 3'd2, marker);
        push_instr(STORE, 3'd2, 8'hB8);
        park_cpu();
        for (int v = n; v >= 1; v--) begin
            expect_store(8'hB0, data_t'(v));
        end
        expect_store(8'hB8, marker);
        run_program(3 * n + 6, base);
        check_stores("jnz_loop", base);
        finish_test("jnz_loop");
    endtask

    task automatic stage_timing();
        data_t first;
        data_t second;
        int    base;
        int    gap;
        for (int k = 0; k < 4; k++) begin
            clear_program();
            first  = random_bits(8);
            second = random_bits(8);
            push_instr(MOVIR, 3'd1, first);
            push_instr(MOVIR, 3'd2, second);
            push_instr(STORE, 3'd1, 8'hC0);
            expect_store(8'hC0, first);
            for (int n = 0; n < k; n++) begin
                // Odd slots use the reserved opcode
                if (n % 2 == 0) begin
                    push_instr(NOP, 3'd0, 8'd0);
                end else begin
                    push_instr(JZR, 3'd0, 8'd0);
                end
            end
            push_instr(STORE, 3'd2, 8'hC1);
            expect_store(8'hC1, second);
            park_cpu();
            run_program(7 + k, base);
            check_stores("stage_timing", base);
            gap = seen_cycle[base + 1] - seen_cycle[base];
            if (gap != 5 + 4 * k) begin
                report_mismatch("stage_timing", $sformatf("store gap with %0d fillers", k),
                                5 + 4 * k, gap);
            end
        end
        finish_test("stage_timing");
    endtask

    initial begin
        reset     = 1'b1;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        mov_store();
        reg_arith();
        imm_arith();
        load_path();
        jnz_loop();
        stage_timing();
        $display("Tests: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== tiny_cpu.f ====
src/cpu_cfg_pkg.sv
src/isa_pkg.sv
src/alu.sv
src/register_file.sv
src/unified_ram.sv
src/exec_unit.sv
src/tiny_cpu.sv
sim/tiny_cpu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns \
    --top-module tiny_cpu_tb -f tiny_cpu.f -o tiny_cpu_sim

output=$(./obj_dir/tiny_cpu_sim)
echo "$output"

if echo "$output" | grep -qx "All tests passed"; then
    exit 0
fi
exit 1
